//--- run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -j 0 \
	--top-module tb_fft \
	-f sources.f \
	-o tb_fft

./obj_dir/tb_fft | tee "$LOG"

if grep -qx "No errors" "$LOG"; then
	exit 0
fi
exit 1

//--- sources.f
src/fft_pkg.sv
src/fft_twiddle.sv
src/fft_stage.sv
src/fft_core.sv
src/fft_serial_in.sv
src/fft_serial_out.sv
src/fft_top.sv
tb/fft_assertions.sv
tb/tb_fft.sv

//--- src/fft_core.sv
`timescale 1ns/1ps

module fft_core (
	input  logic            CLK,
	input  logic            RST,
	input  fft_pkg::frame_t samples,
	input  logic            samples_valid,
	output fft_pkg::frame_t spectrum,
	output logic            spectrum_valid
);

	fft_pkg::frame_t chain [4];
	logic [3:0] vld;

	// Bit-reversed input order
	for (genvar i = 0; i < fft_pkg::N_POINTS; i++) begin : g_rev
		localparam int R = ((i & 1) << 2) | (i & 2) | ((i >> 2) & 1);
		assign chain[0][i] = samples[R];
	end

	assign vld[0] = samples_valid;

	for (genvar s = 1; s <= 3; s++) begin : g_stage
		fft_stage #(
			.STAGE(s)
		) u_stage (
			.CLK       (CLK),
			.RST       (RST),
			.din       (chain[s-1]),
			.din_valid (vld[s-1]),
			.dout      (chain[s]),
			.dout_valid(vld[s])
		);
	end

	assign spectrum = chain[3];
	assign spectrum_valid = vld[3];

endmodule

//--- src/fft_pkg.sv
package fft_pkg;

	// Frame and word sizes
	localparam int N_POINTS = 8;
	localparam int SAMPLE_W = 9;
	localparam int OUT_W = SAMPLE_W + 4; // Growth of log2(8) plus one for the twiddles

	// Width of the bit counters in the serial blocks
	localparam int CNT_W = $clog2(OUT_W);

	// W8^1 magnitude as 181/256
	localparam int TW_COEF = 181;
	localparam int TW_SHIFT = 8;

	typedef struct packed {
		logic signed [OUT_W-1:0] re;
		logic signed [OUT_W-1:0] im;
	} cplx_t;

	// Element i is sample or bin i
	typedef cplx_t [N_POINTS-1:0] frame_t;

	// One serial bit per sample, bit i for sample i
	typedef struct packed {
		logic [N_POINTS-1:0] re;
		logic [N_POINTS-1:0] im;
	} lane_bits_t;

endpackage

//--- src/fft_serial_in.sv
`timescale 1ns/1ps

module fft_serial_in (
	input  logic                CLK,
	input  logic                RST,
	input  logic                load,
	input  fft_pkg::lane_bits_t in_bits,
	output logic                ready,
	output fft_pkg::frame_t     samples,
	output logic                samples_valid
);

	logic [fft_pkg::N_POINTS-1:0][fft_pkg::SAMPLE_W-1:0] sh_re;
	logic [fft_pkg::N_POINTS-1:0][fft_pkg::SAMPLE_W-1:0] sh_im;
	logic [fft_pkg::N_POINTS-1:0][fft_pkg::SAMPLE_W-1:0] nxt_re;
	logic [fft_pkg::N_POINTS-1:0][fft_pkg::SAMPLE_W-1:0] nxt_im;
	logic [fft_pkg::CNT_W-1:0] cnt; // Cycle number within the frame
	logic busy;
	logic accept;
	logic shift_en;
	logic last;

	assign ready = !busy;
	assign accept = load && ready;
	assign shift_en = accept || (busy && cnt < fft_pkg::CNT_W'(fft_pkg::SAMPLE_W));
	assign last = busy && cnt == fft_pkg::CNT_W'(fft_pkg::SAMPLE_W - 1);

	// Frame counter, busy for OUT_W cycles from the load
	always_ff @(posedge CLK or posedge RST) begin
		if (RST) begin
			busy <= 1'b0;
			cnt <= '0;
		end else if (accept) begin
			busy <= 1'b1;
			cnt <= fft_pkg::CNT_W'(1);
		end else if (busy) begin
			if (cnt == fft_pkg::CNT_W'(fft_pkg::OUT_W - 1)) begin
				busy <= 1'b0;
				cnt <= '0;
			end else begin
				cnt <= cnt + 1'b1;
			end
		end
	end

	// LSB first, new bit enters at the top
	always_comb begin
		for (int i = 0; i < fft_pkg::N_POINTS; i++) begin
			nxt_re[i] = {in_bits.re[i], sh_re[i][fft_pkg::SAMPLE_W-1:1]};
			nxt_im[i] = {in_bits.im[i], sh_im[i][fft_pkg::SAMPLE_W-1:1]};
		end
	end

	always_ff @(posedge CLK or posedge RST) begin
		if (RST) begin
			sh_re <= '0;
			sh_im <= '0;
			samples <= '0;
			samples_valid <= 1'b0;
		end else begin
			samples_valid <= last;
			if (shift_en) begin
				sh_re <= nxt_re;
				sh_im <= nxt_im;
			end
			if (last) begin
				for (int i = 0; i < fft_pkg::N_POINTS; i++) begin
					samples[i].re <= {{(fft_pkg::OUT_W - fft_pkg::SAMPLE_W){nxt_re[i][fft_pkg::SAMPLE_W-1]}},
						nxt_re[i]};
					samples[i].im <= {{(fft_pkg::OUT_W - fft_pkg::SAMPLE_W){nxt_im[i][fft_pkg::SAMPLE_W-1]}},
						nxt_im[i]};
				end
			end
		end
	end

endmodule

//--- src/fft_serial_out.sv
`timescale 1ns/1ps

module fft_serial_out (
	input  logic                CLK,
	input  logic                RST,
	input  fft_pkg::frame_t     spectrum,
	input  logic                spectrum_valid,
	output logic                out_valid,
	output fft_pkg::lane_bits_t out_bits
);

	fft_pkg::frame_t sh;
	logic [fft_pkg::CNT_W-1:0] cnt; // Bits already sent

	always_ff @(posedge CLK or posedge RST) begin
		if (RST) begin
			sh <= '0;
			cnt <= '0;
			out_valid <= 1'b0;
		end else if (spectrum_valid) begin
			// A new frame may land right on the last bit of the previous one
			sh <= spectrum;
			cnt <= '0;
			out_valid <= 1'b1;
		end else if (out_valid) begin
			for (int i = 0; i < fft_pkg::N_POINTS; i++) begin
				sh[i].re <= sh[i].re >> 1;
				sh[i].im <= sh[i].im >> 1;
			end
			if (cnt == fft_pkg::CNT_W'(fft_pkg::OUT_W - 1)) begin
				cnt <= '0;
				out_valid <= 1'b0;
			end else begin
				cnt <= cnt + 1'b1;
			end
		end
	end

	always_comb begin
		for (int i = 0; i < fft_pkg::N_POINTS; i++) begin
			out_bits.re[i] = sh[i].re[0];
			out_bits.im[i] = sh[i].im[0];
		end
	end

endmodule

//--- src/fft_stage.sv
`timescale 1ns/1ps

module fft_stage #(
	parameter int STAGE = 1
) (
	input  logic            CLK,
	input  logic            RST,
	input  fft_pkg::frame_t din,
	input  logic            din_valid,
	output fft_pkg::frame_t dout,
	output logic            dout_valid
);

	localparam int H = 1 << (STAGE - 1); // Half span

	fft_pkg::frame_t nxt;

	for (genvar bf = 0; bf < fft_pkg::N_POINTS / 2; bf++) begin : g_bfly
		// Lower position of this butterfly and its twiddle index
		localparam int LO = (bf / H) * 2 * H + bf % H;
		localparam int K = (bf % H) * 4 / H;

		fft_pkg::cplx_t a;
		fft_pkg::cplx_t b;
		fft_pkg::cplx_t t;

		assign a = din[LO];
		assign b = din[LO + H];

		if (K == 0) begin : g_w0
			assign t = b;
		end else if (K == 2) begin : g_w2
			assign t = '{re: b.im, im: -b.re}; // Multiply by -j
		end else begin : g_wodd
			fft_twiddle u_twiddle (
				.din        (b),
				.odd_quarter(K == 3),
				.dout       (t)
			);
		end

		assign nxt[LO] = '{re: a.re + t.re, im: a.im + t.im};
		assign nxt[LO + H] = '{re: a.re - t.re, im: a.im - t.im};
	end

	always_ff @(posedge CLK or posedge RST) begin
		if (RST) begin
			dout <= '0;
			dout_valid <= 1'b0;
		end else begin
			dout_valid <= din_valid;
			if (din_valid) begin
				dout <= nxt;
			end
		end
	end

endmodule

//--- src/fft_top.sv
`timescale 1ns/1ps

module fft_top (
	input  logic                CLK,
	input  logic                RST,
	input  logic                load,
	input  fft_pkg::lane_bits_t in_bits,
	output logic                ready,
	output logic                out_valid,
	output fft_pkg::lane_bits_t out_bits
);

	fft_pkg::frame_t samples;
	fft_pkg::frame_t spectrum;
	logic samples_valid;
	logic spectrum_valid;

	fft_serial_in u_serial_in (
		.CLK          (CLK),
		.RST          (RST),
		.load         (load),
		.in_bits      (in_bits),
		.ready        (ready),
		.samples      (samples),
		.samples_valid(samples_valid)
	);

	// Three registered butterfly stages
	fft_core u_core (
		.CLK           (CLK),
		.RST           (RST),
		.samples       (samples),
		.samples_valid (samples_valid),
		.spectrum      (spectrum),
		.spectrum_valid(spectrum_valid)
	);

	fft_serial_out u_serial_out (
		.CLK           (CLK),
		.RST           (RST),
		.spectrum      (spectrum),
		.spectrum_valid(spectrum_valid),
		.out_valid     (out_valid),
		.out_bits      (out_bits)
	);

endmodule

//--- src/fft_twiddle.sv
`timescale 1ns/1ps

module fft_twiddle (
	input  fft_pkg::cplx_t din,
	input  logic           odd_quarter, // 0 for W1, 1 for W3
	output fft_pkg::cplx_t dout
);

	localparam int P_W = fft_pkg::OUT_W + 10;
	localparam logic signed [P_W-1:0] COEF = P_W'(fft_pkg::TW_COEF);

	logic signed [fft_pkg::OUT_W:0] sum;
	logic signed [fft_pkg::OUT_W:0] diff;
	logic signed [P_W-1:0] p_sum;
	logic signed [P_W-1:0] p_diff;
	logic signed [P_W-1:0] p_nsum;
	logic signed [P_W-1:0] s_sum;
	logic signed [P_W-1:0] s_diff;
	logic signed [P_W-1:0] s_nsum;

	assign sum = din.re + din.im;
	assign diff = din.im - din.re;

	// Full products, floor by arithmetic shift
	assign p_sum = P_W'(sum) * COEF;
	assign p_diff = P_W'(diff) * COEF;
	assign p_nsum = -p_sum; // Negated before the shift so the floor stays exact

	assign s_sum = p_sum >>> fft_pkg::TW_SHIFT;
	assign s_diff = p_diff >>> fft_pkg::TW_SHIFT;
	assign s_nsum = p_nsum >>> fft_pkg::TW_SHIFT;

	always_comb begin
		if (odd_quarter) begin
			dout.re = s_diff[fft_pkg::OUT_W-1:0];
			dout.im = s_nsum[fft_pkg::OUT_W-1:0];
		end else begin
			dout.re = s_sum[fft_pkg::OUT_W-1:0];
			dout.im = s_diff[fft_pkg::OUT_W-1:0];
		end
	end

endmodule

//--- tb/fft_assertions.sv
`timescale 1ns/1ps

module fft_assertions (
	input logic CLK,
	input logic RST,
	input logic load,
	input logic ready,
	input logic out_valid
);

	localparam int SPAN = fft_pkg::OUT_W; // Load to first output bit

	logic accept;

	assign accept = load && ready;

	// Input side busy window
	a_ready_falls: assert property (@(posedge CLK) disable iff (RST)
		$past(accept) |-> !ready)
		else $error("ready stayed high after an accepted load");

	a_ready_low: assert property (@(posedge CLK) disable iff (RST)
		$past(accept, SPAN - 1) |-> !ready)
		else $error("ready returned too early after an accepted load");

	a_ready_back: assert property (@(posedge CLK) disable iff (RST)
		$past(accept, SPAN) |-> ready)
		else $error("ready did not return 13 cycles after an accepted load");

	a_out_start: assert property (@(posedge CLK) disable iff (RST)
		$past(accept, SPAN) |-> out_valid)
		else $error("out_valid missing 13 cycles after an accepted load");

	a_out_rise: assert property (@(posedge CLK) disable iff (RST)
		$rose(out_valid) |-> $past(accept, SPAN))
		else $error("out_valid rose without a load 13 cycles before");

	a_out_hold: assert property (@(posedge CLK) disable iff (RST)
		$past(accept, 2 * SPAN - 1) |-> out_valid)
		else $error("out_valid dropped before the 13th result bit");

	a_out_fall: assert property (@(posedge CLK) disable iff (RST)
		$fell(out_valid) |-> $past(accept, 2 * SPAN))
		else $error("out_valid fell at the wrong time");

	a_reset_idle: assert property (@(posedge CLK)
		$past(RST) |-> !out_valid)
		else $error("out_valid high during or right after reset");

endmodule

bind fft_top fft_assertions u_assertions (
	.CLK      (CLK),
	.RST      (RST),
	.load     (load),
	.ready    (ready),
	.out_valid(out_valid)
);

//--- tb/tb_fft.sv
`timescale 1ns/1ps

module tb_fft;

	localparam int N_DIRECTED = 4;
	localparam int N_RANDOM = 12;
	localparam int N_ROWS = N_DIRECTED + N_RANDOM;
	localparam int WATCHDOG_CYCLES = (N_ROWS + 4) * 30;
	localparam int NP = fft_pkg::N_POINTS;

	logic CLK;
	logic RST;
	logic load;
	fft_pkg::lane_bits_t in_bits;
	logic ready;
	logic out_valid;
	fft_pkg::lane_bits_t out_bits;

	// Stimulus table, one frame per row
	string row_name [N_ROWS];
	int stim_re [N_ROWS][NP];
	int stim_im [N_ROWS][NP];
	int exp_re [N_ROWS][NP];
	int exp_im [N_ROWS][NP];
	bit row_glitch [N_ROWS]; // Stray load pulse after the frame

	int seed = 82;
	int errors = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int accepted = 0;
	int frames_done = 0;
	int bit_cnt = 0;
	int pending_rows [$]; // Rows accepted and not yet seen at the output
	logic [fft_pkg::OUT_W-1:0] acc_re [NP];
	logic [fft_pkg::OUT_W-1:0] acc_im [NP];

	fft_top u_dut (
		.CLK      (CLK),
		.RST      (RST),
		.load     (load),
		.in_bits  (in_bits),
		.ready    (ready),
		.out_valid(out_valid),
		.out_bits (out_bits)
	);

	initial CLK = 1'b0;
	always #5 CLK = ~CLK;

	function automatic int bit_reverse(input int idx);
		int r;
		r = 0;
		for (int b = 0; b < $clog2(NP); b++) begin
			if (idx & (1 << b)) begin
				r = r | (1 << ($clog2(NP) - 1 - b));
			end
		end
		return r;
	endfunction

	// Reference DIT FFT on plain integers
	task automatic compute_spectrum(input int row);
		int vr [NP];
		int vi [NP];
		int h;
		int k;
		int lo;
		int hi;
		int tr;
		int ti;
		for (int i = 0; i < NP; i++) begin
			vr[i] = stim_re[row][bit_reverse(i)];
			vi[i] = stim_im[row][bit_reverse(i)];
		end
		for (int s = 1; s <= 3; s++) begin
			h = 1 << (s - 1);
			for (int g = 0; g < NP; g += 2 * h) begin
				for (int j = 0; j < h; j++) begin
					lo = g + j;
					hi = lo + h;
					k = j * NP / (2 * h);
					case (k)
						0: begin
							tr = vr[hi];
							ti = vi[hi];
						end
						1: begin
							tr = (fft_pkg::TW_COEF * (vr[hi] + vi[hi])) >>> fft_pkg::TW_SHIFT;
							ti = (fft_pkg::TW_COEF * (vi[hi] - vr[hi])) >>> fft_pkg::TW_SHIFT;
						end
						2: begin
							tr = vi[hi];
							ti = -vr[hi];
						end
						default: begin
							tr = (fft_pkg::TW_COEF * (vi[hi] - vr[hi])) >>> fft_pkg::TW_SHIFT;
							ti = (-fft_pkg::TW_COEF * (vr[hi] + vi[hi])) >>> fft_pkg::TW_SHIFT;
						end
					endcase
					vr[hi] = vr[lo] - tr;
					vi[hi] = vi[lo] - ti;
					vr[lo] = vr[lo] + tr;
					vi[lo] = vi[lo] + ti;
				end
			end
		end
		for (int i = 0; i < NP; i++) begin
			exp_re[row][i] = vr[i];
			exp_im[row][i] = vi[i];
		end
	endtask

	task automatic fill_table();
		logic [fft_pkg::SAMPLE_W-1:0] raw;
		for (int r = 0; r < N_ROWS; r++) begin
			row_glitch[r] = (r % 4 == 1);
			for (int i = 0; i < NP; i++) begin
				stim_re[r][i] = 0;
				stim_im[r][i] = 0;
				exp_re[r][i] = 0;
				exp_im[r][i] = 0;
			end
		end
		row_name[0] = "impulse";
		stim_re[0][0] = 100;
		for (int i = 0; i < NP; i++) begin
			exp_re[0][i] = 100;
		end
		row_name[1] = "constant real";
		row_name[2] = "full scale";
		row_name[3] = "constant imaginary";
		for (int i = 0; i < NP; i++) begin
			stim_re[1][i] = 10;
			stim_re[2][i] = -256;
			stim_im[2][i] = -256;
			stim_im[3][i] = -7;
		end
		exp_re[1][0] = 80;
		exp_re[2][0] = -2048;
		exp_im[2][0] = -2048;
		exp_im[3][0] = -56;
		for (int r = N_DIRECTED; r < N_ROWS; r++) begin
			row_name[r] = $sformatf("random %0d", r - N_DIRECTED);
			for (int i = 0; i < NP; i++) begin
				raw = 9'($random(seed));
				stim_re[r][i] = int'($signed(raw));
				raw = 9'($random(seed));
				stim_im[r][i] = int'($signed(raw));
			end
			compute_spectrum(r);
		end
	endtask

	// Bit k of every sample of a row
	function automatic fft_pkg::lane_bits_t lane_bits(input int row, input int k);
		fft_pkg::lane_bits_t b;
		for (int i = 0; i < NP; i++) begin
			b.re[i] = 1'(stim_re[row][i] >>> k);
			b.im[i] = 1'(stim_im[row][i] >>> k);
		end
		return b;
	endfunction

	task automatic check_idle_after_reset();
		bit bad;
		bad = 0;
		repeat (3) begin
			@(posedge CLK);
			assert (ready && !out_valid) else begin
				$display("error at %0d ns: after reset ready is %0b and out_valid is %0b",
					$time, ready, out_valid);
				errors++;
				bad = 1;
			end
		end
		tests_run++;
		if (bad) begin
			tests_failed++;
		end
		$display("test reset idle: %s", bad ? "fail" : "pass");
	endtask

	task automatic send_row(input int row);
		@(posedge CLK);
		load <= 1'b1;
		in_bits <= lane_bits(row, 0);
		@(posedge CLK);
		while (!ready) begin // Hold the request until taken
			@(posedge CLK);
		end
		pending_rows.push_back(row);
		load <= 1'b0;
		in_bits <= lane_bits(row, 1);
		for (int k = 2; k < fft_pkg::SAMPLE_W; k++) begin
			@(posedge CLK);
			in_bits <= lane_bits(row, k);
		end
		@(posedge CLK);
		in_bits <= '0;
		if (row_glitch[row]) begin
			load <= 1'b1;
			in_bits <= 16'($random(seed));
			@(posedge CLK);
			assert (!ready) else begin
				$display("stray load pulse met ready high, so the DUT took it as a frame");
				errors++;
			end
			load <= 1'b0;
			in_bits <= '0;
		end
	endtask

	task automatic check_frame();
		int row;
		int got_re;
		int got_im;
		bit bad;
		bad = 0;
		assert (pending_rows.size() > 0) else begin
			$display("an output frame appeared with no accepted load waiting for it");
			errors++;
		end
		if (pending_rows.size() > 0) begin
			row = pending_rows.pop_front();
			for (int i = 0; i < NP; i++) begin
				got_re = int'($signed(acc_re[i]));
				got_im = int'($signed(acc_im[i]));
				assert (got_re == exp_re[row][i] && got_im == exp_im[row][i]) else begin
					$display("error at %0d ns: test %0d (%s) bin %0d is %0d, %0d, expected %0d, %0d",
						$time, row, row_name[row], i, got_re, got_im,
						exp_re[row][i], exp_im[row][i]);
					errors++;
					bad = 1;
				end
			end
			tests_run++;
			if (bad) begin
				tests_failed++;
			end
			$display("test %0d %s: %s", row, row_name[row], bad ? "fail" : "pass");
		end
		frames_done++;
	endtask

	// Loads the DUT accepted, seen from outside
	always @(posedge CLK) begin
		if (!RST && load && ready) begin
			accepted++;
		end
	end

	// Rebuild each result frame, LSB first
	always @(negedge CLK) begin
		if (!RST && out_valid) begin
			for (int i = 0; i < NP; i++) begin
				acc_re[i] = {out_bits.re[i], acc_re[i][fft_pkg::OUT_W-1:1]};
				acc_im[i] = {out_bits.im[i], acc_im[i][fft_pkg::OUT_W-1:1]};
			end
			bit_cnt++;
			if (bit_cnt == fft_pkg::OUT_W) begin
				bit_cnt = 0;
				check_frame();
			end
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge CLK);
		$display("timeout: the results did not arrive within %0d cycles", WATCHDOG_CYCLES);
		$display("Errors found");
		$finish;
	end

	initial begin
		RST = 1'b1;
		load = 1'b0;
		in_bits = '0;
		fill_table();
		repeat (5) @(posedge CLK);
		RST <= 1'b0;
		check_idle_after_reset();
		for (int r = 0; r < N_ROWS; r++) begin
			send_row(r);
		end
		wait (frames_done == N_ROWS);
		repeat (2 * fft_pkg::OUT_W) @(posedge CLK); // Room for a stray frame
		assert (accepted == N_ROWS && frames_done == N_ROWS) else begin
			$display("the DUT accepted %0d loads and sent %0d frames, but %0d rows were sent",
				accepted, frames_done, N_ROWS);
			errors++;
		end
		$display("tests run %0d, passed %0d, failed %0d, failed checks %0d",
			tests_run, tests_run - tests_failed, tests_failed, errors);
		if (errors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule
